// ==== flist.f ====
src/rvb_isa_pkg.sv
src/rvb_core_pkg.sv
src/rvb_fu_if.sv
src/rvb_decoder.sv
src/rvb_dispatch.sv
src/rvb_simple.sv
src/rvb_bitcnt.sv
src/rvb_clmul.sv
src/rvb_top.sv
tests/rvb_top_assert.sv
tests/rvb_checker.sv
tests/tb_rvb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/10ps -Wall
TOP        = tb_rvb
FILELIST   = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_rvb.sv ====
`timescale 1ns/10ps

module tb_rvb;

	localparam int num_insns = 2000;
	localparam int cycle_limit = num_insns * (rvb_core_pkg::clmul_cycles + 4) * 2;

	logic                clock;
	logic                reset;
	logic                din_valid;
	logic                din_ready;
	logic                din_decoded;
	logic [31:0]         din_insn;
	rvb_core_pkg::data_t din_rs1;
	rvb_core_pkg::data_t din_rs2;
	rvb_core_pkg::data_t din_rs3;
	logic                dout_valid;
	logic                dout_ready;
	rvb_core_pkg::data_t dout_rd;
	int                  decode_errors;
	int                  ready_errors;
	int                  value_errors;
	int                  order_errors;
	int                  pending;
	int                  seed;
	int                  cycles;
	logic                taken;

	rvb_top i_dut (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.din_rs3     (din_rs3),
		.din_insn    (din_insn),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd)
	);

	rvb_checker i_checker (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic rvb_core_pkg::data_t pick_operand();
		int sel;
		sel = $random(seed) & 15;
		case (sel)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			4: return 32'h0000_0001;
			default: return $random(seed);
		endcase
	endfunction

	function automatic rvb_isa_pkg::insn_u with_r(input rvb_isa_pkg::insn_u w,
			input logic [6:0] f7, input logic [2:0] f3);
		w.r.opcode = rvb_isa_pkg::opcode_op;
		w.r.funct7 = f7;
		w.r.funct3 = f3;
		return w;
	endfunction

	function automatic rvb_isa_pkg::insn_u with_i(input rvb_isa_pkg::insn_u w,
			input logic [11:0] imm);
		w.i.opcode = rvb_isa_pkg::opcode_opimm;
		w.i.funct3 = rvb_isa_pkg::funct3_bitcnt;
		w.i.imm12 = imm;
		return w;
	endfunction

	// Random register fields, one kept row or a fully random word
	function automatic logic [31:0] make_insn();
		rvb_isa_pkg::insn_u w;
		int row;
		w = $random(seed);
		row = $random(seed) & 15;
		if (($random(seed) & 7) == 0)
			return w;
		case (row)
			0: w = with_r(w, rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_andn);
			1: w = with_r(w, rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_orn);
			2: w = with_r(w, rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_xnor);
			3: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_min);
			4: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_max);
			5: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_minu);
			6: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_maxu);
			7: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmul);
			8: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmulr);
			9: w = with_r(w, rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmulh);
			10: w = with_r(w, rvb_isa_pkg::funct7_pack, rvb_isa_pkg::funct3_pack);
			11: w = with_r(w, {w.r.funct7[6:2], rvb_isa_pkg::funct2_cmix}, rvb_isa_pkg::funct3_cmix);
			12: w = with_r(w, {w.r.funct7[6:2], rvb_isa_pkg::funct2_cmix}, rvb_isa_pkg::funct3_cmov);
			13: w = with_i(w, rvb_isa_pkg::imm12_clz);
			14: w = with_i(w, rvb_isa_pkg::imm12_ctz);
			default: w = with_i(w, rvb_isa_pkg::imm12_pcnt);
		endcase
		return w;
	endfunction

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int total;
		seed = 32'ha7eee837;
		reset = 1'b1;
		din_valid = 1'b1;  // Decoded word offered while in reset
		din_insn = with_i('0, rvb_isa_pkg::imm12_pcnt);
		din_rs1 = '0;
		din_rs2 = '0;
		din_rs3 = '0;
		dout_ready = 1'b0;
		repeat (16) @(posedge clock);
		#10 reset = 1'b0;
		din_valid = 1'b0;
		din_insn = '0;
		@(posedge clock);  // One idle cycle after reset
		#10;
		for (int n = 0; n < num_insns; n++) begin
			din_insn = make_insn();
			din_rs1 = pick_operand();
			din_rs2 = pick_operand();
			din_rs3 = pick_operand();
			do begin
				din_valid = ($random(seed) & 3) != 0;
				dout_ready = ($random(seed) & 3) != 0;
				@(negedge clock);
				taken = (din_valid && din_ready) || !din_decoded;  // Undecoded words are dropped
				@(posedge clock);
				#10;
			end while (!taken);
		end
		din_valid = 1'b0;
		dout_ready = 1'b1;
		@(posedge clock);
		while (pending != 0)
			@(posedge clock);
		total = decode_errors + ready_errors + value_errors + order_errors +
			i_dut.i_assert.failures;
		$display("Errors: decode %0d, ready %0d, value %0d, order %0d, assertion %0d",
			decode_errors, ready_errors, value_errors, order_errors, i_dut.i_assert.failures);
		if (total == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== tests/rvb_checker.sv ====
`timescale 1ns/10ps

module rvb_checker (
	input  logic                clock,
	input  logic                reset,
	input  logic                din_valid,
	input  logic                din_ready,
	input  logic                din_decoded,
	input  logic [31:0]         din_insn,
	input  rvb_core_pkg::data_t din_rs1,
	input  rvb_core_pkg::data_t din_rs2,
	input  rvb_core_pkg::data_t din_rs3,
	input  logic                dout_valid,
	input  logic                dout_ready,
	input  rvb_core_pkg::data_t dout_rd,
	output int                  decode_errors,
	output int                  ready_errors,
	output int                  value_errors,
	output int                  order_errors,
	output int                  pending
);

	rvb_core_pkg::data_t expected_q [$];  // Results in acceptance order

	function automatic logic [63:0] clmul64(input rvb_core_pkg::data_t a,
			input rvb_core_pkg::data_t b);
		logic [63:0] p;
		p = '0;
		for (int i = 0; i < rvb_core_pkg::xlen; i++) begin
			if (b[i])
				p = p ^ ({32'b0, a} << i);
		end
		return p;
	endfunction

	function automatic int lead_zeros(input rvb_core_pkg::data_t a);
		int n;
		n = 0;
		while (n < rvb_core_pkg::xlen && !a[rvb_core_pkg::xlen - 1 - n])
			n++;
		return n;
	endfunction

	function automatic int trail_zeros(input rvb_core_pkg::data_t a);
		int n;
		n = 0;
		while (n < rvb_core_pkg::xlen && !a[n])
			n++;
		return n;
	endfunction

	// Returns whether the word is a kept row, and its result
	function automatic logic reference_result(input rvb_isa_pkg::insn_u w,
			input rvb_core_pkg::data_t a, input rvb_core_pkg::data_t b,
			input rvb_core_pkg::data_t c, output rvb_core_pkg::data_t res);
		logic [63:0] p;
		logic ok;
		p = clmul64(a, b);
		ok = 1'b1;
		res = '0;
		if (w.r.opcode == rvb_isa_pkg::opcode_op &&
				w.r.funct7[1:0] == rvb_isa_pkg::funct2_cmix) begin
			case (w.r.funct3)
				rvb_isa_pkg::funct3_cmix: res = (a & b) | (c & ~b);
				rvb_isa_pkg::funct3_cmov: res = (b != 0) ? a : c;
				default: ok = 1'b0;
			endcase
		end else if (w.r.opcode == rvb_isa_pkg::opcode_op) begin
			case ({w.r.funct7, w.r.funct3})
				{rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_andn}: res = a & ~b;
				{rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_orn}: res = a | ~b;
				{rvb_isa_pkg::funct7_logicneg, rvb_isa_pkg::funct3_xnor}: res = ~(a ^ b);
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_min}: begin
					res = ($signed(a) < $signed(b)) ? a : b;
				end
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_max}: begin
					res = ($signed(a) > $signed(b)) ? a : b;
				end
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_minu}: res = (a < b) ? a : b;
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_maxu}: res = (a > b) ? a : b;
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmul}: res = p[31:0];
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmulr}: res = p[62:31];
				{rvb_isa_pkg::funct7_minmax, rvb_isa_pkg::funct3_clmulh}: res = p[63:32];
				{rvb_isa_pkg::funct7_pack, rvb_isa_pkg::funct3_pack}: res = {b[15:0], a[15:0]};
				default: ok = 1'b0;
			endcase
		end else if (w.i.opcode == rvb_isa_pkg::opcode_opimm &&
				w.i.funct3 == rvb_isa_pkg::funct3_bitcnt) begin
			case (w.i.imm12)
				rvb_isa_pkg::imm12_clz: res = lead_zeros(a);
				rvb_isa_pkg::imm12_ctz: res = trail_zeros(a);
				rvb_isa_pkg::imm12_pcnt: res = $countones(a);
				default: ok = 1'b0;
			endcase
		end else begin
			ok = 1'b0;
		end
		return ok;
	endfunction

	// Sampled mid-cycle, where inputs and outputs are settled
	always @(negedge clock) begin
		rvb_core_pkg::data_t want;
		logic ok;
		logic ready_want;
		if (reset) begin
			expected_q.delete();
			decode_errors = 0;
			ready_errors = 0;
			value_errors = 0;
			order_errors = 0;
		end else begin
			ok = reference_result(din_insn, din_rs1, din_rs2, din_rs3, want);
			if (din_decoded !== ok) begin
				$display("Fail at %0t: din_decoded for insn %h expected %b got %b",
					$time, din_insn, ok, din_decoded);
				decode_errors++;
			end
			// Busy while an accepted item has not reached the output register
			ready_want = ok && (expected_q.size() == int'(dout_valid));
			if (din_ready !== ready_want) begin
				$display("Fail at %0t: din_ready expected %b got %b",
					$time, ready_want, din_ready);
				ready_errors++;
			end
			if (din_valid && din_ready)
				expected_q.push_back(want);
			if (dout_valid && dout_ready) begin
				if (expected_q.size() == 0) begin
					$display("Error at %0t: a result came out with no instruction pending", $time);
					order_errors++;
				end else begin
					want = expected_q.pop_front();
					if (dout_rd !== want) begin
						$display("Fail at %0t: dout_rd expected %h got %h", $time, want, dout_rd);
						value_errors++;
					end
				end
			end
		end
		pending = expected_q.size();
	end

endmodule

// ==== tests/rvb_top_assert.sv ====
`timescale 1ns/10ps

module rvb_top_assert (
	input logic                clock,
	input logic                reset,
	input logic                din_ready,
	input logic                din_decoded,
	input logic                dout_valid,
	input logic                dout_ready,
	input rvb_core_pkg::data_t dout_rd,
	input logic                clmul_take,
	input logic                clmul_done
);

	int reset_fails = 0;
	int ready_fails = 0;
	int stall_fails = 0;
	int clmul_fails = 0;
	int failures;

	assign failures = reset_fails + ready_fails + stall_fails + clmul_fails;

	// Quiet in reset and on the first cycle after it
	a_reset_quiet: assert property (@(posedge clock)
		reset |-> !din_ready ##1 (!din_ready && !dout_valid))
		else begin
			reset_fails++;
			$error("din_ready or dout_valid high around reset");
		end

	a_ready_decoded: assert property (@(posedge clock) din_ready |-> din_decoded)
		else begin
			ready_fails++;
			$error("din_ready high for an instruction that is not decoded");
		end

	a_out_stall: assert property (@(posedge clock) disable iff (reset)
		dout_valid && !dout_ready |=> dout_valid && $stable(dout_rd))
		else begin
			stall_fails++;
			$error("output changed while dout_ready was low");
		end

	a_clmul_latency: assert property (@(posedge clock) disable iff (reset)
		$rose(clmul_done) |-> $past(clmul_take, rvb_core_pkg::clmul_cycles))
		else begin
			clmul_fails++;
			$error("multiplier done at the wrong cycle");
		end

endmodule

bind rvb_top rvb_top_assert i_assert (
	.clock       (clock),
	.reset       (reset),
	.din_ready   (din_ready),
	.din_decoded (din_decoded),
	.dout_valid  (dout_valid),
	.dout_ready  (dout_ready),
	.dout_rd     (dout_rd),
	.clmul_take  (clmul_req.valid && clmul_req.ready),
	.clmul_done  (clmul_done)
);

// ==== src/rvb_top.sv ====
`timescale 1ns/10ps

module rvb_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                din_valid,
	output logic                din_ready,
	output logic                din_decoded,
	input  rvb_core_pkg::data_t din_rs1,
	input  rvb_core_pkg::data_t din_rs2,
	input  rvb_core_pkg::data_t din_rs3,
	input  logic [31:0]         din_insn,
	output logic                dout_valid,
	input  logic                dout_ready,
	output rvb_core_pkg::data_t dout_rd
);

	rvb_core_pkg::unit_e unit;
	rvb_core_pkg::op_t   op;
	logic                out_ready;
	logic                simple_done;
	logic                bitcnt_done;
	logic                clmul_done;
	rvb_core_pkg::data_t simple_rd;
	rvb_core_pkg::data_t bitcnt_rd;
	rvb_core_pkg::data_t clmul_rd;

	rvb_fu_if simple_req ();
	rvb_fu_if bitcnt_req ();
	rvb_fu_if clmul_req ();

	rvb_decoder i_decoder (
		.insn (din_insn),
		.unit (unit),
		.op   (op)
	);

	rvb_dispatch i_dispatch (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.din_rs3     (din_rs3),
		.unit        (unit),
		.op          (op),
		.simple_req  (simple_req),
		.bitcnt_req  (bitcnt_req),
		.clmul_req   (clmul_req),
		.simple_done (simple_done),
		.bitcnt_done (bitcnt_done),
		.clmul_done  (clmul_done),
		.simple_rd   (simple_rd),
		.bitcnt_rd   (bitcnt_rd),
		.clmul_rd    (clmul_rd),
		.out_ready   (out_ready),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd)
	);

	rvb_simple i_simple (
		.req       (simple_req),
		.out_ready (out_ready),
		.done      (simple_done),
		.rd        (simple_rd)
	);

	rvb_bitcnt i_bitcnt (
		.req       (bitcnt_req),
		.out_ready (out_ready),
		.done      (bitcnt_done),
		.rd        (bitcnt_rd)
	);

	rvb_clmul i_clmul (
		.clock     (clock),
		.reset     (reset),
		.req       (clmul_req),
		.out_ready (out_ready),
		.done      (clmul_done),
		.rd        (clmul_rd)
	);

endmodule

// ==== src/rvb_clmul.sv ====
`timescale 1ns/10ps

module rvb_clmul (
	input  logic                clock,
	input  logic                reset,
	rvb_fu_if.unit              req,
	input  logic                out_ready,
	output logic                done,
	output rvb_core_pkg::data_t rd
);

	typedef logic [$clog2(rvb_core_pkg::clmul_cycles)-1:0] cnt_t;

	logic                          running;
	logic                          take;
	cnt_t                          cnt;
	logic [2*rvb_core_pkg::xlen-1:0] acc;
	logic [2*rvb_core_pkg::xlen-1:0] acc_in;
	logic [2*rvb_core_pkg::xlen-1:0] acc_next;
	logic [2*rvb_core_pkg::xlen-1:0] a_q;
	logic [2*rvb_core_pkg::xlen-1:0] step_a;
	rvb_core_pkg::data_t           b_q;
	rvb_core_pkg::data_t           step_b;
	rvb_core_pkg::op_t             op_q;

	assign req.ready = !running && !done;  // Idle
	assign take = req.valid && req.ready;

	// The accepting edge already folds the first slice of rs2
	assign step_a = take ? {{rvb_core_pkg::xlen{1'b0}}, req.rs1} : a_q;
	assign step_b = take ? req.rs2 : b_q;
	assign acc_in = take ? '0 : acc;

	always_comb begin
		acc_next = acc_in;
		for (int i = 0; i < rvb_core_pkg::clmul_step; i++) begin
			if (step_b[i])
				acc_next = acc_next ^ (step_a << i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else if (take) begin
			running <= 1'b1;
			cnt <= cnt_t'(1);
		end else if (running) begin
			cnt <= cnt + 1'b1;
			if (cnt == cnt_t'(rvb_core_pkg::clmul_cycles - 1)) begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end else if (done && out_ready) begin
			done <= 1'b0;  // Result taken
		end
	end

	always_ff @(posedge clock) begin
		if (take || running) begin
			acc <= acc_next;
			a_q <= step_a << rvb_core_pkg::clmul_step;
			b_q <= step_b >> rvb_core_pkg::clmul_step;
		end
		if (take)
			op_q <= req.op;
	end

	always_comb begin
		case (op_q)
			rvb_core_pkg::op_clmulr: rd = acc[2*rvb_core_pkg::xlen-2:rvb_core_pkg::xlen-1];
			rvb_core_pkg::op_clmulh: rd = acc[2*rvb_core_pkg::xlen-1:rvb_core_pkg::xlen];
			default: rd = acc[rvb_core_pkg::xlen-1:0];
		endcase
	end

endmodule

// ==== src/rvb_bitcnt.sv ====
`timescale 1ns/10ps

module rvb_bitcnt (
	rvb_fu_if.unit              req,
	input  logic                out_ready,
	output logic                done,
	output rvb_core_pkg::data_t rd
);

	rvb_core_pkg::data_t src;
	rvb_core_pkg::data_t tz;
	rvb_core_pkg::data_t ones;

	assign req.ready = out_ready;
	assign done = req.valid;

	// CLZ is counted as trailing zeros of the reversed word
	assign src = (req.op == rvb_core_pkg::op_clz) ?
		rvb_core_pkg::data_t'({<<{req.rs1}}) : req.rs1;

	always_comb begin
		tz = rvb_core_pkg::xlen;  // All-zero operand
		ones = '0;
		for (int i = rvb_core_pkg::xlen - 1; i >= 0; i--) begin
			if (src[i])
				tz = rvb_core_pkg::data_t'(i);  // Lowest set bit wins
			ones = ones + rvb_core_pkg::data_t'(src[i]);
		end
	end

	assign rd = (req.op == rvb_core_pkg::op_pcnt) ? ones : tz;

endmodule

// ==== src/rvb_simple.sv ====
`timescale 1ns/10ps

module rvb_simple (
	rvb_fu_if.unit              req,
	input  logic                out_ready,
	output logic                done,
	output rvb_core_pkg::data_t rd
);

	logic lt_s;
	logic lt_u;

	// Single cycle, so the request passes straight to the output register
	assign req.ready = out_ready;
	assign done = req.valid;

	assign lt_s = $signed(req.rs1) < $signed(req.rs2);
	assign lt_u = req.rs1 < req.rs2;

	always_comb begin
		case (req.op)
			rvb_core_pkg::op_andn: rd = req.rs1 & ~req.rs2;
			rvb_core_pkg::op_orn: rd = req.rs1 | ~req.rs2;
			rvb_core_pkg::op_xnor: rd = ~(req.rs1 ^ req.rs2);
			rvb_core_pkg::op_min: rd = lt_s ? req.rs1 : req.rs2;
			rvb_core_pkg::op_max: rd = lt_s ? req.rs2 : req.rs1;
			rvb_core_pkg::op_minu: rd = lt_u ? req.rs1 : req.rs2;
			rvb_core_pkg::op_maxu: rd = lt_u ? req.rs2 : req.rs1;
			rvb_core_pkg::op_pack: begin
				rd = {req.rs2[rvb_core_pkg::xlen/2-1:0], req.rs1[rvb_core_pkg::xlen/2-1:0]};
			end
			rvb_core_pkg::op_cmix: rd = (req.rs1 & req.rs2) | (req.rs3 & ~req.rs2);  // rs2 is the mask
			rvb_core_pkg::op_cmov: rd = (req.rs2 != '0) ? req.rs1 : req.rs3;
			default: rd = '0;
		endcase
	end

endmodule

// ==== src/rvb_dispatch.sv ====
`timescale 1ns/10ps

module rvb_dispatch (
	input  logic                clock,
	input  logic                reset,
	input  logic                din_valid,
	output logic                din_ready,
	output logic                din_decoded,
	input  rvb_core_pkg::data_t din_rs1,
	input  rvb_core_pkg::data_t din_rs2,
	input  rvb_core_pkg::data_t din_rs3,
	input  rvb_core_pkg::unit_e unit,
	input  rvb_core_pkg::op_t   op,
	rvb_fu_if.issue             simple_req,
	rvb_fu_if.issue             bitcnt_req,
	rvb_fu_if.issue             clmul_req,
	input  logic                simple_done,
	input  logic                bitcnt_done,
	input  logic                clmul_done,
	input  rvb_core_pkg::data_t simple_rd,
	input  rvb_core_pkg::data_t bitcnt_rd,
	input  rvb_core_pkg::data_t clmul_rd,
	output logic                out_ready,
	output logic                dout_valid,
	input  logic                dout_ready,
	output rvb_core_pkg::data_t dout_rd
);

	logic                busy;
	logic                accept;
	logic                any_done;
	logic                simple_v;
	logic                bitcnt_v;
	logic                clmul_v;
	rvb_core_pkg::data_t rs1_q;
	rvb_core_pkg::data_t rs2_q;
	rvb_core_pkg::data_t rs3_q;
	rvb_core_pkg::op_t   op_q;

	assign din_decoded = unit != rvb_core_pkg::unit_none;
	assign din_ready = !reset && !busy && din_decoded;
	assign accept = din_valid && din_ready;
	assign out_ready = !dout_valid || dout_ready;  // Output register free
	assign any_done = simple_done || bitcnt_done || clmul_done;

	assign simple_req.valid = simple_v;
	assign simple_req.rs1 = rs1_q;
	assign simple_req.rs2 = rs2_q;
	assign simple_req.rs3 = rs3_q;
	assign simple_req.op = op_q;
	assign bitcnt_req.valid = bitcnt_v;
	assign bitcnt_req.rs1 = rs1_q;
	assign bitcnt_req.rs2 = rs2_q;
	assign bitcnt_req.rs3 = rs3_q;
	assign bitcnt_req.op = op_q;
	assign clmul_req.valid = clmul_v;
	assign clmul_req.rs1 = rs1_q;
	assign clmul_req.rs2 = rs2_q;
	assign clmul_req.rs3 = rs3_q;
	assign clmul_req.op = op_q;

	// One-hot request valid, dropped once the unit takes it
	always_ff @(posedge clock) begin
		if (reset) begin
			simple_v <= 1'b0;
			bitcnt_v <= 1'b0;
			clmul_v <= 1'b0;
		end else if (accept) begin
			simple_v <= unit == rvb_core_pkg::unit_simple;
			bitcnt_v <= unit == rvb_core_pkg::unit_bitcnt;
			clmul_v <= unit == rvb_core_pkg::unit_clmul;
		end else begin
			if (simple_req.ready)
				simple_v <= 1'b0;
			if (bitcnt_req.ready)
				bitcnt_v <= 1'b0;
			if (clmul_req.ready)
				clmul_v <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rs1_q <= din_rs1;
			rs2_q <= din_rs2;
			rs3_q <= din_rs3;
			op_q <= op;
		end
	end

	// Busy from accept until the result reaches the output register
	always_ff @(posedge clock) begin
		if (reset)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (out_ready && any_done)
			busy <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (reset)
			dout_valid <= 1'b0;
		else if (out_ready)
			dout_valid <= any_done;
	end

	always_ff @(posedge clock) begin
		if (out_ready && any_done)
			dout_rd <= simple_done ? simple_rd : bitcnt_done ? bitcnt_rd : clmul_rd;
	end

endmodule

// ==== src/rvb_decoder.sv ====
`timescale 1ns/10ps

module rvb_decoder (
	input  rvb_isa_pkg::insn_u  insn,
	output rvb_core_pkg::unit_e unit,
	output rvb_core_pkg::op_t   op
);

	always_comb begin
		unit = rvb_core_pkg::unit_none;
		op = rvb_core_pkg::op_andn;
		if (insn.r.opcode == rvb_isa_pkg::opcode_op) begin
			if (insn.r.funct7[1:0] == rvb_isa_pkg::funct2_cmix) begin
				unit = rvb_core_pkg::unit_simple;  // rs3 field ignored here
				case (insn.r.funct3)
					rvb_isa_pkg::funct3_cmix: op = rvb_core_pkg::op_cmix;
					rvb_isa_pkg::funct3_cmov: op = rvb_core_pkg::op_cmov;
					default: unit = rvb_core_pkg::unit_none;
				endcase
			end else if (insn.r.funct7 == rvb_isa_pkg::funct7_logicneg) begin
				unit = rvb_core_pkg::unit_simple;
				case (insn.r.funct3)
					rvb_isa_pkg::funct3_andn: op = rvb_core_pkg::op_andn;
					rvb_isa_pkg::funct3_orn: op = rvb_core_pkg::op_orn;
					rvb_isa_pkg::funct3_xnor: op = rvb_core_pkg::op_xnor;
					default: unit = rvb_core_pkg::unit_none;
				endcase
			end else if (insn.r.funct7 == rvb_isa_pkg::funct7_minmax) begin
				// Upper funct3 half is min/max, lower half multiplies
				unit = insn.r.funct3[2] ? rvb_core_pkg::unit_simple : rvb_core_pkg::unit_clmul;
				case (insn.r.funct3)
					rvb_isa_pkg::funct3_clmul: op = rvb_core_pkg::op_clmul;
					rvb_isa_pkg::funct3_clmulr: op = rvb_core_pkg::op_clmulr;
					rvb_isa_pkg::funct3_clmulh: op = rvb_core_pkg::op_clmulh;
					rvb_isa_pkg::funct3_min: op = rvb_core_pkg::op_min;
					rvb_isa_pkg::funct3_max: op = rvb_core_pkg::op_max;
					rvb_isa_pkg::funct3_minu: op = rvb_core_pkg::op_minu;
					rvb_isa_pkg::funct3_maxu: op = rvb_core_pkg::op_maxu;
					default: unit = rvb_core_pkg::unit_none;
				endcase
			end else if (insn.r.funct7 == rvb_isa_pkg::funct7_pack &&
					insn.r.funct3 == rvb_isa_pkg::funct3_pack) begin
				unit = rvb_core_pkg::unit_simple;
				op = rvb_core_pkg::op_pack;
			end
		end else if (insn.i.opcode == rvb_isa_pkg::opcode_opimm &&
				insn.i.funct3 == rvb_isa_pkg::funct3_bitcnt) begin
			unit = rvb_core_pkg::unit_bitcnt;  // Selected by imm12
			case (insn.i.imm12)
				rvb_isa_pkg::imm12_clz: op = rvb_core_pkg::op_clz;
				rvb_isa_pkg::imm12_ctz: op = rvb_core_pkg::op_ctz;
				rvb_isa_pkg::imm12_pcnt: op = rvb_core_pkg::op_pcnt;
				default: unit = rvb_core_pkg::unit_none;
			endcase
		end
	end

endmodule

// ==== src/rvb_fu_if.sv ====
`timescale 1ns/10ps

interface rvb_fu_if;

	logic                valid;
	logic                ready;
	rvb_core_pkg::data_t rs1;
	rvb_core_pkg::data_t rs2;
	rvb_core_pkg::data_t rs3;
	rvb_core_pkg::op_t   op;

	// Issue stage side
	modport issue (output valid, output rs1, output rs2, output rs3, output op, input ready);

	// Functional unit side
	modport unit (input valid, input rs1, input rs2, input rs3, input op, output ready);

endinterface

// ==== src/rvb_core_pkg.sv ====
package rvb_core_pkg;

	localparam int xlen = 32;
	localparam int clmul_step = 8;                     // rs2 bits folded per cycle
	localparam int clmul_cycles = xlen / clmul_step;

	typedef logic [xlen-1:0] data_t;

	typedef enum logic [1:0] {
		unit_none,
		unit_simple,
		unit_bitcnt,
		unit_clmul
	} unit_e;

	// Operation code, meaning depends on the target unit
	typedef logic [3:0] op_t;

	localparam op_t op_andn = 4'd0;
	localparam op_t op_orn = 4'd1;
	localparam op_t op_xnor = 4'd2;
	localparam op_t op_min = 4'd3;
	localparam op_t op_max = 4'd4;
	localparam op_t op_minu = 4'd5;
	localparam op_t op_maxu = 4'd6;
	localparam op_t op_pack = 4'd7;
	localparam op_t op_cmix = 4'd8;
	localparam op_t op_cmov = 4'd9;

	localparam op_t op_clz = 4'd0;
	localparam op_t op_ctz = 4'd1;
	localparam op_t op_pcnt = 4'd2;

	localparam op_t op_clmul = 4'd0;
	localparam op_t op_clmulr = 4'd1;
	localparam op_t op_clmulh = 4'd2;

endpackage

// ==== src/rvb_isa_pkg.sv ====
package rvb_isa_pkg;

	// One instruction word seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} insn_u;

	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_opimm = 7'b0010011;

	localparam logic [6:0] funct7_logicneg = 7'b0100000;  // ANDN ORN XNOR
	localparam logic [6:0] funct7_minmax = 7'b0000101;    // MIN/MAX and CLMUL rows
	localparam logic [6:0] funct7_pack = 7'b0000100;
	localparam logic [1:0] funct2_cmix = 2'b11;           // Top five bits carry rs3

	localparam logic [2:0] funct3_andn = 3'b111;
	localparam logic [2:0] funct3_orn = 3'b110;
	localparam logic [2:0] funct3_xnor = 3'b100;
	localparam logic [2:0] funct3_clmul = 3'b001;
	localparam logic [2:0] funct3_clmulr = 3'b010;
	localparam logic [2:0] funct3_clmulh = 3'b011;
	localparam logic [2:0] funct3_min = 3'b100;
	localparam logic [2:0] funct3_max = 3'b101;
	localparam logic [2:0] funct3_minu = 3'b110;
	localparam logic [2:0] funct3_maxu = 3'b111;
	localparam logic [2:0] funct3_pack = 3'b100;
	localparam logic [2:0] funct3_cmix = 3'b001;
	localparam logic [2:0] funct3_cmov = 3'b101;
	localparam logic [2:0] funct3_bitcnt = 3'b001;

	localparam logic [11:0] imm12_clz = 12'h600;
	localparam logic [11:0] imm12_ctz = 12'h601;
	localparam logic [11:0] imm12_pcnt = 12'h602;

endpackage
